//--- list.f
logic/i2c_cmd_pkg.sv
logic/codec_init_pkg.sv
logic/init_table.sv
logic/cfg_watch.sv
logic/init_sequencer.sv
logic/i2c_init_top.sv
sim/tb_i2c_init.sv

//--- Makefile
TOP := tb_i2c_init

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

//--- sim/tb_i2c_init.sv
// testbench for the i2c init sequencer, master model, reference walk and stream checker
`timescale 1ns/10ps

module tb_i2c_init;

    logic                  clk;
    logic                  rst;
    logic                  init_start;
    logic                  spk_enable;
    logic                  mic_boost;
    logic                  cmd_ready      = 1'b1;
    logic                  data_out_ready = 1'b1;
    i2c_cmd_pkg::i2c_cmd_t cmd;
    logic                  cmd_valid;
    logic [7:0]            data_out;
    logic                  data_out_valid;
    logic                  busy;

    // back-pressure on or off
    logic stall_en = 1'b0;

    // expected streams from the reference, accepted words from the master model
    i2c_cmd_pkg::i2c_cmd_t exp_cmd_q[$];
    i2c_cmd_pkg::i2c_cmd_t got_cmd_q[$];
    logic [7:0]            exp_data_q[$];
    logic [7:0]            got_data_q[$];

    int          value_errs = 0;
    int          other_errs = 0;
    logic [31:0] rdy_rng    = 32'ha08b437b;
    logic [31:0] cfg_rng    = 32'ha08b437b;
    logic [7:0]  cur_patch;
    logic [1:0]  pick;

    i2c_init_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // signal select 1 byte is base | boost mask | speaker mask
    function automatic logic [7:0] patch_for(input logic spk, input logic boost);
        logic [7:0] b;
        b = codec_init_pkg::patch_base;
        b = b | (boost ? codec_init_pkg::boost_on : codec_init_pkg::boost_off);
        if (spk) begin
            b = b | codec_init_pkg::spk_on;
        end
        return b;
    endfunction

    // walk the table from first and append expected commands and bytes
    function automatic void add_expected(input int first, input logic [7:0] patch);
        i2c_cmd_pkg::entry_t   e;
        i2c_cmd_pkg::i2c_cmd_t c;
        logic [6:0]            addr;
        logic                  pending;
        bit                    done;
        int                    i;
        addr    = '0;
        pending = 1'b0;
        done    = 1'b0;
        for (i = first; i < codec_init_pkg::table_len && !done; i++) begin
            e = (i == int'(codec_init_pkg::patch_idx)) ? {1'b1, patch}
                                                       : codec_init_pkg::init_table[i];
            c.address = addr;
            if (e[8]) begin
                // start only on the first write after an address
                c.start = pending;
                c.write = 1'b1;
                c.stop  = 1'b0;
                exp_cmd_q.push_back(c);
                exp_data_q.push_back(e[7:0]);
                pending = 1'b0;
            end else if (e[8:7] == 2'b01) begin
                addr    = e[6:0];
                pending = 1'b1;
            end else if (e == 9'h041 || e == 9'h000) begin
                // send stop and end of table both give a stop command
                c.start = 1'b0;
                c.write = 1'b0;
                c.stop  = 1'b1;
                exp_cmd_q.push_back(c);
                done = (e == 9'h000);
            end
        end
    endfunction

    task automatic check_val(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %0h got %0h", name, expected, actual);
            value_errs++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        other_errs++;
    endtask

    // busy sampled on the falling edge
    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            report_failure({"timeout waiting for ", what});
        end
    endtask

    // one more edge so the checker has seen every accepted word
    task automatic check_drained(input string what);
        @(negedge clk);
        if (exp_cmd_q.size() != 0 || exp_data_q.size() != 0) begin
            report_failure({what, " ended with expected words never sent"});
        end
        exp_cmd_q.delete();
        exp_data_q.delete();
    endtask

    task automatic full_run(input logic keep_start);
        add_expected(0, cur_patch);
        @(posedge clk);
        init_start <= 1'b1;
        wait_busy(1'b1, "full run to start");
        if (!keep_start) begin
            @(posedge clk);
            init_start <= 1'b0;
        end
        wait_busy(1'b0, "full run to end");
        check_drained("full run");
    endtask

    task automatic set_cfg(input logic spk, input logic boost);
        @(posedge clk);
        spk_enable <= spk;
        mic_boost  <= boost;
        cur_patch = patch_for(spk, boost);
    endtask

    // i2c master model logs accepted words and draws new ready values
    always @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            got_cmd_q.push_back(cmd);
        end
        if (data_out_valid && data_out_ready) begin
            got_data_q.push_back(data_out);
        end
        rdy_rng = lcg_next(rdy_rng);
        cmd_ready      <= !stall_en || rdy_rng[31:30] != 2'b00;
        data_out_ready <= !stall_en || rdy_rng[29:28] != 2'b00;
    end

    // accepted words compared in order
    always @(negedge clk) begin : compare
        i2c_cmd_pkg::i2c_cmd_t c;
        logic [7:0]            d;
        // busy must cover any pending word
        if (rst === 1'b0 && (cmd_valid || data_out_valid)) begin
            check_val("busy", 16'd1, 16'(busy));
        end
        while (got_cmd_q.size() > 0) begin
            c = got_cmd_q.pop_front();
            if (exp_cmd_q.size() == 0) begin
                report_failure("command accepted beyond the expected stream");
            end else begin
                check_val("cmd", 16'(exp_cmd_q.pop_front()), 16'(c));
            end
        end
        while (got_data_q.size() > 0) begin
            d = got_data_q.pop_front();
            if (exp_data_q.size() == 0) begin
                report_failure("data byte accepted beyond the expected stream");
            end else begin
                check_val("data_out", 16'(exp_data_q.pop_front()), 16'(d));
            end
        end
    end

    initial begin
        rst        = 1'b1;
        init_start = 1'b0;
        spk_enable = 1'b1;
        mic_boost  = 1'b0;
        // reset view is speaker on, boost off
        cur_patch = patch_for(1'b1, 1'b0);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("cmd_valid", 16'd0, 16'(cmd_valid));
        check_val("data_out_valid", 16'd0, 16'(data_out_valid));
        check_val("busy", 16'd0, 16'(busy));

        // full run with ready always high
        full_run(1'b0);
        // and again with stalls
        stall_en <= 1'b1;
        full_run(1'b0);

        // held start must not rerun
        full_run(1'b1);
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_val("busy", 16'd0, 16'(busy));
        end
        @(posedge clk);
        init_start <= 1'b0;
        full_run(1'b0);

        // all four combos while idle in order 11 01 00 10 so each is a change
        for (int k = 0; k < 4; k++) begin
            set_cfg(~(k[0] ^ k[1]), ~k[1]);
            add_expected(int'(codec_init_pkg::restart_idx), cur_patch);
            wait_busy(1'b1, "re-run to start");
            wait_busy(1'b0, "re-run to end");
            check_drained("re-run");
        end

        // change early in a full run so entry 41 is patched before its fetch
        cfg_rng = lcg_next(lcg_next(cfg_rng));
        pick    = cfg_rng[31:30];
        if (pick == {spk_enable, mic_boost}) begin
            pick[1] = ~pick[1];
        end
        add_expected(0, patch_for(pick[1], pick[0]));
        add_expected(int'(codec_init_pkg::restart_idx), patch_for(pick[1], pick[0]));
        @(posedge clk);
        init_start <= 1'b1;
        wait_busy(1'b1, "full run to start");
        set_cfg(pick[1], pick[0]);
        @(posedge clk);
        init_start <= 1'b0;
        wait_busy(1'b0, "full run to end");
        wait_busy(1'b1, "queued re-run to start");
        wait_busy(1'b0, "queued re-run to end");
        check_drained("full run with queued re-run");
        full_run(1'b0);

        $display("closing: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- logic/i2c_init_top.sv
// top level of the i2c init sequencer, table, config watcher and sequencer
`timescale 1ns/10ps

module i2c_init_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           init_start,
    // from another clock domain
    input  logic                           spk_enable,
    input  logic                           mic_boost,
    // i2c master command channel
    output i2c_cmd_pkg::i2c_cmd_t          cmd,
    output logic                           cmd_valid,
    input  logic                           cmd_ready,
    // i2c master write data channel
    output logic [i2c_cmd_pkg::byte_w-1:0] data_out,
    output logic                           data_out_valid,
    input  logic                           data_out_ready,
    output logic                           busy
);

    // patch path
    logic                           patch_we;
    logic [i2c_cmd_pkg::byte_w-1:0] patch_byte;

    // re-run handshake
    logic cfg_req;
    logic cfg_ack;

    // table read port
    logic [codec_init_pkg::table_aw-1:0] rd_idx;
    i2c_cmd_pkg::entry_t                 rd_entry;

    init_table i_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .patch_we   (patch_we),
        .patch_byte (patch_byte)
    );

    cfg_watch i_cfg (
        .clk        (clk),
        .rst        (rst),
        .spk_enable (spk_enable),
        .mic_boost  (mic_boost),
        .patch_we   (patch_we),
        .patch_byte (patch_byte),
        .cfg_req    (cfg_req),
        .cfg_ack    (cfg_ack)
    );

    init_sequencer i_seq (
        .clk            (clk),
        .rst            (rst),
        .init_start     (init_start),
        .cfg_req        (cfg_req),
        .cfg_ack        (cfg_ack),
        .rd_idx         (rd_idx),
        .rd_entry       (rd_entry),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy)
    );

endmodule

//--- logic/init_sequencer.sv
// fetch/decode FSM over the init table with command and data output registers
`timescale 1ns/10ps

module init_sequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 init_start,
    input  logic                                 cfg_req,
    output logic                                 cfg_ack,
    output logic [codec_init_pkg::table_aw-1:0]  rd_idx,
    input  i2c_cmd_pkg::entry_t                  rd_entry,
    output i2c_cmd_pkg::i2c_cmd_t                cmd,
    output logic                                 cmd_valid,
    input  logic                                 cmd_ready,
    output logic [i2c_cmd_pkg::byte_w-1:0]       data_out,
    output logic                                 data_out_valid,
    input  logic                                 data_out_ready,
    output logic                                 busy
);

    i2c_cmd_pkg::seq_state_t state_q, state_d;
    i2c_cmd_pkg::opcode_t    op;

    // table index of the entry arriving on rd_entry
    logic [codec_init_pkg::table_aw-1:0] idx_q, idx_d;

    // blocks a held init_start from rerunning
    logic start_latch_q, start_latch_d;

    i2c_cmd_pkg::i2c_cmd_t           cmd_q, cmd_d;
    logic                            cmd_valid_q, cmd_valid_d;
    logic [i2c_cmd_pkg::byte_w-1:0]  data_q, data_d;
    logic                            data_valid_q, data_valid_d;
    logic                            busy_q;

    // outputs idle on both channels
    logic out_clear;

    assign op        = i2c_cmd_pkg::decode_entry(rd_entry);
    assign out_clear = ~cmd_valid_q & ~data_valid_q;

    // config re-run wins over a fresh start
    assign cfg_ack = (state_q == i2c_cmd_pkg::st_idle) & out_clear & cfg_req;

    // next index goes to the table and the entry comes back next cycle
    assign rd_idx = idx_d;

    always_comb begin
        state_d       = state_q;
        idx_d         = idx_q;
        start_latch_d = start_latch_q;
        data_d        = data_q;

        // flags drop once the master takes the command
        cmd_d = cmd_q;
        if (cmd_valid_q & cmd_ready) begin
            cmd_d.start = 1'b0;
            cmd_d.write = 1'b0;
            cmd_d.stop  = 1'b0;
        end
        cmd_valid_d  = cmd_valid_q & ~cmd_ready;
        data_valid_d = data_valid_q & ~data_out_ready;

        // decode only with both channels empty
        if (out_clear) begin
            case (state_q)
                i2c_cmd_pkg::st_idle: begin
                    if (cfg_req) begin
                        idx_d   = codec_init_pkg::restart_idx;
                        state_d = i2c_cmd_pkg::st_run;
                    end else if (init_start & ~start_latch_q) begin
                        idx_d         = '0;
                        start_latch_d = 1'b1;
                        state_d       = i2c_cmd_pkg::st_run;
                    end
                end
                i2c_cmd_pkg::st_run: begin
                    case (op)
                        i2c_cmd_pkg::op_data: begin
                            // write with pending start and address
                            cmd_d.write  = 1'b1;
                            cmd_d.stop   = 1'b0;
                            cmd_valid_d  = 1'b1;
                            data_d       = rd_entry[i2c_cmd_pkg::byte_w-1:0];
                            data_valid_d = 1'b1;
                            idx_d        = idx_q + 1'b1;
                        end
                        i2c_cmd_pkg::op_addr: begin
                            // arm the start with no output yet
                            cmd_d.address = rd_entry[i2c_cmd_pkg::dev_addr_w-1:0];
                            cmd_d.start   = 1'b1;
                            idx_d         = idx_q + 1'b1;
                        end
                        i2c_cmd_pkg::op_send_stop: begin
                            cmd_d.start = 1'b0;
                            cmd_d.write = 1'b0;
                            cmd_d.stop  = 1'b1;
                            cmd_valid_d = 1'b1;
                            idx_d       = idx_q + 1'b1;
                        end
                        i2c_cmd_pkg::op_end: begin
                            // final stop and back to idle
                            cmd_d.start = 1'b0;
                            cmd_d.write = 1'b0;
                            cmd_d.stop  = 1'b1;
                            cmd_valid_d = 1'b1;
                            state_d     = i2c_cmd_pkg::st_idle;
                        end
                        default: begin
                            // unknown entry is skipped
                            idx_d = idx_q + 1'b1;
                        end
                    endcase
                end
                default: begin
                    state_d = i2c_cmd_pkg::st_idle;
                end
            endcase
        end

        // latch only lives while init_start stays high
        start_latch_d = start_latch_d & init_start;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= i2c_cmd_pkg::st_idle;
            idx_q         <= '0;
            start_latch_q <= 1'b0;
            cmd_valid_q   <= 1'b0;
            data_valid_q  <= 1'b0;
            busy_q        <= 1'b0;
        end else begin
            state_q       <= state_d;
            idx_q         <= idx_d;
            start_latch_q <= start_latch_d;
            cmd_valid_q   <= cmd_valid_d;
            data_valid_q  <= data_valid_d;
            // stays up until the last word is taken
            busy_q        <= (state_q != i2c_cmd_pkg::st_idle) | cmd_valid_d | data_valid_d;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        cmd_q  <= cmd_d;
        data_q <= data_d;
    end

    assign cmd            = cmd_q;
    assign cmd_valid      = cmd_valid_q;
    assign data_out       = data_q;
    assign data_out_valid = data_valid_q;
    assign busy           = busy_q;

    // words hold under back-pressure
    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid & ~cmd_ready |=> cmd_valid & $stable(cmd));
    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        data_out_valid & ~data_out_ready |=> data_out_valid & $stable(data_out));

    // a re-run is only taken between runs once the last word went out
    a_ack_idle: assert property (@(posedge clk) disable iff (rst)
        cfg_ack |-> ~busy);

endmodule

//--- logic/cfg_watch.sv
// config input synchronizers, change detect, patch byte and held re-run request
`timescale 1ns/10ps

module cfg_watch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           spk_enable,
    input  logic                           mic_boost,
    output logic                           patch_we,
    output logic [i2c_cmd_pkg::byte_w-1:0] patch_byte,
    output logic                           cfg_req,
    input  logic                           cfg_ack
);

    // two flop synchronizer stages
    codec_init_pkg::cfg_t cfg_meta;
    codec_init_pkg::cfg_t cfg_sync;

    // last synchronized value seen
    codec_init_pkg::cfg_t cfg_prev;

    logic                           cfg_change;
    logic [i2c_cmd_pkg::byte_w-1:0] byte_next;

    // sync chain starts from the table default, so no change after reset
    // unless the inputs really differ
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_meta <= codec_init_pkg::cfg_default;
            cfg_sync <= codec_init_pkg::cfg_default;
            cfg_prev <= codec_init_pkg::cfg_default;
        end else begin
            cfg_meta <= '{spk: spk_enable, boost: mic_boost};
            cfg_sync <= cfg_meta;
            cfg_prev <= cfg_sync;
        end
    end

    assign cfg_change = (cfg_sync != cfg_prev);

    // base bits, one of the two boost masks, speaker bit if enabled
    always_comb begin
        byte_next = codec_init_pkg::patch_base;
        if (cfg_sync.boost) begin
            byte_next = byte_next | codec_init_pkg::boost_on;
        end else begin
            byte_next = byte_next | codec_init_pkg::boost_off;
        end
        if (cfg_sync.spk) begin
            byte_next = byte_next | codec_init_pkg::spk_on;
        end
    end

    // one patch pulse per change, request held until acked
    // a change in the ack cycle keeps the request up
    always_ff @(posedge clk) begin
        if (rst) begin
            patch_we <= 1'b0;
            cfg_req  <= 1'b0;
        end else begin
            patch_we <= cfg_change;
            cfg_req  <= cfg_change | (cfg_req & ~cfg_ack);
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_change) begin
            patch_byte <= byte_next;
        end
    end

    // request only drops after the sequencer took it
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(cfg_req) |-> $past(cfg_ack));

endmodule

//--- logic/init_table.sv
// init table storage with one patchable entry and a registered read port
`timescale 1ns/10ps

module init_table (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [codec_init_pkg::table_aw-1:0]  rd_idx,
    output i2c_cmd_pkg::entry_t                  rd_entry,
    input  logic                                 patch_we,
    input  logic [i2c_cmd_pkg::byte_w-1:0]       patch_byte
);

    // the one writable entry
    i2c_cmd_pkg::entry_t patch_entry;

    // everything else comes straight from the constant table
    i2c_cmd_pkg::entry_t rom_entry;

    // reset puts back the default signal select 1 byte
    always_ff @(posedge clk) begin
        if (rst) begin
            patch_entry <= codec_init_pkg::init_table[codec_init_pkg::patch_idx];
        end else if (patch_we) begin
            // always stored as a data entry
            patch_entry <= {1'b1, patch_byte};
        end
    end

    // past the last entry reads as end of table
    always_comb begin
        if (int'(rd_idx) < codec_init_pkg::table_len) begin
            rom_entry = codec_init_pkg::init_table[rd_idx];
        end else begin
            rom_entry = i2c_cmd_pkg::ent_end;
        end
    end

    // registered read with the entry one cycle after rd_idx
    always_ff @(posedge clk) begin
        if (rd_idx == codec_init_pkg::patch_idx) begin
            rd_entry <= patch_entry;
        end else begin
            rd_entry <= rom_entry;
        end
    end

endmodule

//--- logic/codec_init_pkg.sv
// init table contents, table size, patch and restart indices, configuration masks
package codec_init_pkg;

    localparam int table_len = 43;
    localparam int table_aw  = 6;

    // clock chip at 0x6a, then codec at 0x12, then end
    // each write is address, register byte, value byte
    localparam i2c_cmd_pkg::entry_t init_table [table_len] = '{
        // clock chip
        {2'b01, 7'h6a}, {1'b1, 8'h17}, {1'b1, 8'h04},
        {2'b01, 7'h6a}, {1'b1, 8'h18}, {1'b1, 8'h40},
        {2'b01, 7'h6a}, {1'b1, 8'h1e}, {1'b1, 8'he8},
        {2'b01, 7'h6a}, {1'b1, 8'h1f}, {1'b1, 8'h80},
        {2'b01, 7'h6a}, {1'b1, 8'h2d}, {1'b1, 8'h01},
        {2'b01, 7'h6a}, {1'b1, 8'h2e}, {1'b1, 8'h10},
        {2'b01, 7'h6a}, {1'b1, 8'h60}, {1'b1, 8'h3b},
        // codec, dummy write to reg 00h first
        {2'b01, 7'h12}, {1'b1, 8'h00}, {1'b1, 8'h00},
        // mode control 1, pll and audio format
        {2'b01, 7'h12}, {1'b1, 8'h05}, {1'b1, 8'h33},
        // power management 1
        {2'b01, 7'h12}, {1'b1, 8'h00}, {1'b1, 8'hc5},
        // power management 2, speaker path on
        {2'b01, 7'h12}, {1'b1, 8'h01}, {1'b1, 8'hb6},
        // signal select 3
        {2'b01, 7'h12}, {1'b1, 8'h04}, {1'b1, 8'h47},
        // signal select 2, speaker gain
        {2'b01, 7'h12}, {1'b1, 8'h03}, {1'b1, 8'h80},
        // signal select 1, patched from the config inputs
        {2'b01, 7'h12}, {1'b1, 8'h02}, {1'b1, 8'hae},
        i2c_cmd_pkg::ent_end
    };

    // signal select 1 data byte and the start of its write
    localparam logic [table_aw-1:0] patch_idx   = 6'd41;
    localparam logic [table_aw-1:0] restart_idx = 6'd39;

    // patched byte is base | boost mask | speaker mask
    localparam logic [7:0] patch_base = 8'h2a;
    localparam logic [7:0] boost_on   = 8'h40;
    localparam logic [7:0] boost_off  = 8'h04;
    localparam logic [7:0] spk_on     = 8'h80;

    typedef struct packed {
        logic spk;
        logic boost;
    } cfg_t;

    // speaker on, boost off, gives 0xae
    localparam cfg_t cfg_default = '{spk: 1'b1, boost: 1'b0};

endpackage

//--- logic/i2c_cmd_pkg.sv
// table entry format, command opcodes, i2c master command struct, sequencer states
package i2c_cmd_pkg;

    // field widths
    localparam int entry_w    = 9;
    localparam int dev_addr_w = 7;
    localparam int byte_w     = 8;

    // one table entry
    // 1 dddddddd  write data byte
    // 01 aaaaaaa  start write to address
    // 001000001   send i2c stop
    // 000000000   end of table
    typedef logic [entry_w-1:0] entry_t;

    localparam entry_t ent_end       = 9'h000;
    localparam entry_t ent_send_stop = 9'h041;

    // decoded entry kinds
    typedef enum logic [2:0] {
        op_end,
        op_addr,
        op_data,
        op_send_stop,
        op_skip
    } opcode_t;

    typedef enum logic {
        st_idle,
        st_run
    } seq_state_t;

    // command word toward the i2c master, 10 bits
    typedef struct packed {
        logic [dev_addr_w-1:0] address;
        logic                  start;
        logic                  write;
        logic                  stop;
    } i2c_cmd_t;

    // classify one entry, anything unlisted is skipped
    function automatic opcode_t decode_entry(entry_t e);
        if (e[entry_w-1]) begin
            return op_data;
        end else if (e[entry_w-1 -: 2] == 2'b01) begin
            return op_addr;
        end else if (e == ent_send_stop) begin
            return op_send_stop;
        end else if (e == ent_end) begin
            return op_end;
        end
        return op_skip;
    endfunction

endpackage
